// ==== files.f ====
usb_stream_pkg.sv
mmio_cmd_pkg.sv
mmio_ep_out.sv
packet_fifo.sv
mmio_apb_master.sv
mmio_bridge_top.sv
tb_mmio_bridge.sv

// ==== mmio_apb_master.sv ====
`timescale 1ns/1ps

module mmio_apb_master (
  input  logic                      clock,
  input  logic                      rst_n_i,
  input  logic                      cmd_valid_i,
  output logic                      cmd_ready_o,
  input  mmio_cmd_pkg::mmio_cmd_t   cmd_i,
  input  logic                      rd_valid_i,
  output logic                      rd_ready_o,
  input  usb_stream_pkg::usb_beat_t rd_beat_i,
  output logic                      done_o,
  output logic [31:0]               paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output logic [31:0]               pwdata_o,
  input  logic [31:0]               prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i,
  output logic                      resp_valid_o,
  output mmio_cmd_pkg::mmio_resp_t  resp_o
);

  import mmio_cmd_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FILL,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } apb_e;

  apb_e        state_q;
  mmio_cmd_t   cmd_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [15:0] remain_q;
  logic [1:0]  bcnt_q;
  logic        write_q;
  logic        err_q;
  logic [15:0] rdata_q;

  logic        cmd_w;
  logic        rd_w;
  logic        more_w;

  assign cmd_ready_o = state_q == ST_IDLE;
  assign cmd_w       = cmd_valid_i && cmd_ready_o;
  // Buffer is read only while packing, never during a wait state
  assign rd_ready_o  = state_q == ST_FILL;
  assign rd_w        = rd_valid_i && rd_ready_o;
  // Store bytes left after the word in flight
  assign more_w      = cmd_q.op == OP_STORE && remain_q != '0;

  assign psel_o    = state_q inside {ST_SETUP, ST_ACCESS};
  assign penable_o = state_q == ST_ACCESS;
  assign paddr_o   = addr_q;
  assign pwrite_o  = write_q;
  assign pwdata_o  = wdata_q;

  // Response and done share the single RESP cycle
  assign resp_valid_o = state_q == ST_RESP;
  assign done_o       = state_q == ST_RESP;
  assign resp_o       = '{tag: cmd_q.tag, err: err_q, rdata: rdata_q};

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_w) begin
            if (cmd_i.op == OP_SINGLE) begin
              state_q <= ST_SETUP;
            end else if (cmd_i.op == OP_STORE && cmd_i.lenval.len != '0) begin
              state_q <= ST_FILL;
            end else begin
              state_q <= ST_RESP;
            end
          end
        end
        // Fourth byte completes a word
        ST_FILL: begin
          if (rd_w && bcnt_q == 2'd3) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          state_q <= ST_ACCESS;
        end
        ST_ACCESS: begin
          if (pready_i) begin
            state_q <= more_w ? ST_FILL : ST_RESP;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_w) begin
      cmd_q    <= cmd_i;
      // LUN goes out on the top address nibble
      addr_q   <= {cmd_i.lun, cmd_i.adr};
      // Single write data, zero-extended
      wdata_q  <= {16'h0000, cmd_i.lenval.value};
      write_q  <= cmd_i.op == OP_STORE || !cmd_i.dir;
      remain_q <= cmd_i.lenval.len;
      bcnt_q   <= '0;
      // Loads and unknown ops fail at once
      err_q    <= !(cmd_i.op inside {OP_STORE, OP_SINGLE});
      rdata_q  <= '0;
    end
    // Least significant byte first
    if (rd_w) begin
      wdata_q <= {rd_beat_i.data, wdata_q[31:8]};
      bcnt_q  <= bcnt_q + 2'd1;
      if (bcnt_q == 2'd3) begin
        remain_q <= (remain_q > 16'd4) ? remain_q - 16'd4 : '0;
      end
    end
    if (state_q == ST_ACCESS && pready_i) begin
      err_q <= err_q | pslverr_i;
      if (!write_q) begin
        rdata_q <= prdata_i[15:0];
      end
      if (more_w) begin
        addr_q <= addr_q + APB_STEP;
      end
    end
  end

  a_setup_first: assert property (@(posedge clock) disable iff (!rst_n_i)
    $rose(penable_o) |-> $past(psel_o && !penable_o));

  // Address and data hold through wait states
  a_wait_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    penable_o && !pready_i |=> penable_o && $stable(paddr_o) && $stable(pwdata_o));

endmodule

// ==== mmio_bridge_top.sv ====
`timescale 1ns/1ps

module mmio_bridge_top (
  input  logic                      clock,
  input  logic                      rst_n_i,
  input  logic                      set_conf_i,
  input  logic                      clr_conf_i,
  input  logic                      selected_i,
  input  logic                      rx_error_i,
  input  logic                      ack_sent_i,
  input  logic                      usb_valid_i,
  input  usb_stream_pkg::usb_beat_t usb_beat_i,
  output logic                      usb_ready_o,
  output logic                      stalled_o,
  output logic                      resp_valid_o,
  output mmio_cmd_pkg::mmio_resp_t  resp_o,
  output logic [31:0]               paddr_o,
  output logic                      psel_o,
  output logic                      penable_o,
  output logic                      pwrite_o,
  output logic [31:0]               pwdata_o,
  input  logic [31:0]               prdata_i,
  input  logic                      pready_i,
  input  logic                      pslverr_i
);

  import usb_stream_pkg::*;
  import mmio_cmd_pkg::*;

  // Endpoint to master
  logic      cmd_valid;
  logic      cmd_ready;
  mmio_cmd_t cmd;
  logic      done;

  // Endpoint to buffer
  logic      wr_valid;
  logic      wr_ready;
  usb_beat_t wr_beat;
  logic      commit;
  logic      drop;

  // Buffer to master, committed bytes only
  logic      rd_valid;
  logic      rd_ready;
  usb_beat_t rd_beat;

  mmio_ep_out ep_out_i (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .set_conf_i  (set_conf_i),
    .clr_conf_i  (clr_conf_i),
    .selected_i  (selected_i),
    .rx_error_i  (rx_error_i),
    .ack_sent_i  (ack_sent_i),
    .usb_valid_i (usb_valid_i),
    .usb_beat_i  (usb_beat_i),
    .usb_ready_o (usb_ready_o),
    .stalled_o   (stalled_o),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .cmd_o       (cmd),
    .wr_valid_o  (wr_valid),
    .wr_ready_i  (wr_ready),
    .wr_beat_o   (wr_beat),
    .commit_o    (commit),
    .drop_o      (drop),
    .done_i      (done)
  );

  packet_fifo fifo_i (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .wr_valid_i (wr_valid),
    .wr_ready_o (wr_ready),
    .wr_beat_i  (wr_beat),
    .commit_i   (commit),
    .drop_i     (drop),
    .rd_valid_o (rd_valid),
    .rd_ready_i (rd_ready),
    .rd_beat_o  (rd_beat)
  );

  mmio_apb_master apb_i (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .cmd_i        (cmd),
    .rd_valid_i   (rd_valid),
    .rd_ready_o   (rd_ready),
    .rd_beat_i    (rd_beat),
    .done_o       (done),
    .paddr_o      (paddr_o),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .pwrite_o     (pwrite_o),
    .pwdata_o     (pwdata_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

// ==== mmio_cmd_pkg.sv ====
package mmio_cmd_pkg;

  // Command packets open with "TART"
  // Words arrive little-endian, the first wire byte lands in bits [7:0]
  localparam logic [31:0] MMIO_MAGIC = "TART";

  // Address increment between consecutive store words
  localparam logic [31:0] APB_STEP = 32'd4;

  // Op field, low two bits of the last command byte
  typedef enum logic [1:0] {
    // Burst write of buffered Bulk-Out data
    OP_STORE  = 2'b00,
    // One 16-bit APB access, dir picks read or write
    OP_SINGLE = 2'b01,
    // Bulk read, no return path here so it gets an error
    OP_LOAD   = 2'b10
  } mmio_op_e;

  // Bytes 8 and 9 of a command
  typedef union packed {
    // Store byte count, a multiple of 4
    logic [15:0] len;
    // Write data of a single access
    logic [15:0] value;
  } mmio_lenval_u;

  // Decoded command, endpoint to APB master
  typedef struct packed {
    logic [3:0]   tag;
    // High for a read
    logic         dir;
    mmio_op_e     op;
    // Goes out in the top nibble of paddr
    logic [3:0]   lun;
    logic [27:0]  adr;
    mmio_lenval_u lenval;
  } mmio_cmd_t;

  // Response for the host
  typedef struct packed {
    logic [3:0]  tag;
    // PSLVERR seen on any transfer, or an unsupported op
    logic        err;
    // Low half of PRDATA on a single read, zero otherwise
    logic [15:0] rdata;
  } mmio_resp_t;

endpackage

// ==== mmio_ep_out.sv ====
`timescale 1ns/1ps

module mmio_ep_out (
  input  logic                      clock,
  input  logic                      rst_n_i,
  input  logic                      set_conf_i,
  input  logic                      clr_conf_i,
  input  logic                      selected_i,
  input  logic                      rx_error_i,
  input  logic                      ack_sent_i,
  input  logic                      usb_valid_i,
  input  usb_stream_pkg::usb_beat_t usb_beat_i,
  output logic                      usb_ready_o,
  output logic                      stalled_o,
  output logic                      cmd_valid_o,
  input  logic                      cmd_ready_i,
  output mmio_cmd_pkg::mmio_cmd_t   cmd_o,
  output logic                      wr_valid_o,
  input  logic                      wr_ready_i,
  output usb_stream_pkg::usb_beat_t wr_beat_o,
  output logic                      commit_o,
  output logic                      drop_o,
  input  logic                      done_i
);

  import usb_stream_pkg::*;
  import mmio_cmd_pkg::*;

  // Parser states, one per field of the 11-byte packet
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_WORD,
    ST_OP,
    ST_BUSY,
    ST_HALT
  } parse_e;

  parse_e                  state_q;
  logic                    en_q;
  logic [1:0]              sel_q;
  logic [31:0]             word_q;
  mmio_cmd_t               cmd_q;
  logic                    cmd_valid_q;
  logic                    data_q;
  logic                    end_q;
  logic [USB_FRAME_CW-1:0] fcnt_q;

  logic                    clear_w;
  logic                    parsing_w;
  logic                    parse_w;
  logic                    data_w;
  logic                    early_w;
  logic                    dispatch_w;
  logic                    short_w;
  logic [31:0]             word_w;
  logic [USB_FRAME_CW-1:0] fcnt_w;

  // Either configuration pulse resets the endpoint
  assign clear_w   = set_conf_i || clr_conf_i;
  assign parsing_w = state_q inside {ST_IDLE, ST_ADDR, ST_WORD, ST_OP};
  assign stalled_o = state_q == ST_HALT;

  // Data phase follows buffer space, parsing takes a byte every cycle
  assign usb_ready_o = en_q && selected_i && !stalled_o && (data_q ? wr_ready_i : parsing_w);
  assign parse_w     = usb_valid_i && usb_ready_o && !data_q;
  assign data_w      = usb_valid_i && usb_ready_o && data_q;

  // Little-endian word assembly, next byte shifts in from the top
  assign word_w  = {usb_beat_i.data, word_q[31:8]};
  // Packet ends before the op byte
  assign early_w = usb_beat_i.last || !usb_beat_i.keep;
  assign dispatch_w = parse_w && state_q == ST_OP && usb_beat_i.last && usb_beat_i.keep;

  // Store data goes straight to the buffer
  assign wr_valid_o = usb_valid_i && data_q && en_q && selected_i;
  assign wr_beat_o  = usb_beat_i;
  assign commit_o   = ack_sent_i && data_q;
  assign drop_o     = rx_error_i && data_q;

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;

  // Bytes seen so far in this frame, a ZDP adds none
  assign fcnt_w  = fcnt_q + USB_FRAME_CW'(usb_beat_i.keep);
  assign short_w = !usb_beat_i.keep || fcnt_w < USB_FRAME_CW'(USB_MAX_PACKET);

  // Parser FSM
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      sel_q   <= '0;
    end else if (clear_w) begin
      state_q <= ST_IDLE;
      sel_q   <= '0;
    end else if (state_q == ST_BUSY) begin
      // Held until the master has answered
      if (done_i) begin
        state_q <= ST_IDLE;
        sel_q   <= '0;
      end
    end else if (parse_w) begin
      sel_q <= sel_q + 2'd1;
      case (state_q)
        ST_IDLE: begin
          if (early_w) begin
            state_q <= ST_HALT;
          end else if (sel_q == 2'd3) begin
            state_q <= (word_w == MMIO_MAGIC) ? ST_ADDR : ST_HALT;
          end
        end
        ST_ADDR: begin
          if (early_w) begin
            state_q <= ST_HALT;
          end else if (sel_q == 2'd3) begin
            state_q <= ST_WORD;
          end
        end
        ST_WORD: begin
          if (early_w) begin
            state_q <= ST_HALT;
          end else if (sel_q == 2'd1) begin
            state_q <= ST_OP;
          end
        end
        // Byte 10 must carry last, anything else is a bad length
        ST_OP: begin
          state_q <= dispatch_w ? ST_BUSY : ST_HALT;
        end
        default: begin
          state_q <= state_q;
        end
      endcase
    end
  end

  // Field capture
  // Op byte is tag [7:4], dir [3], op [1:0]
  always_ff @(posedge clock) begin
    if (parse_w) begin
      word_q <= word_w;
      if (state_q == ST_ADDR && sel_q == 2'd3) begin
        cmd_q.lun <= word_w[31:28];
        cmd_q.adr <= word_w[27:0];
      end
      if (state_q == ST_WORD && sel_q == 2'd1) begin
        cmd_q.lenval <= word_w[31:16];
      end
      if (state_q == ST_OP) begin
        cmd_q.tag <= usb_beat_i.data[7:4];
        cmd_q.dir <= usb_beat_i.data[3];
        cmd_q.op  <= mmio_op_e'(usb_beat_i.data[1:0]);
      end
    end
  end

  // Enable, command handshake and store data phase
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q        <= 1'b0;
      cmd_valid_q <= 1'b0;
      data_q      <= 1'b0;
      end_q       <= 1'b0;
      fcnt_q      <= '0;
    end else if (clear_w) begin
      en_q        <= set_conf_i && !clr_conf_i;
      cmd_valid_q <= 1'b0;
      data_q      <= 1'b0;
      end_q       <= 1'b0;
      fcnt_q      <= '0;
    end else begin
      if (cmd_valid_q && cmd_ready_i) begin
        cmd_valid_q <= 1'b0;
      end else if (dispatch_w) begin
        cmd_valid_q <= 1'b1;
      end
      if (dispatch_w && usb_beat_i.data[1:0] == OP_STORE) begin
        data_q <= 1'b1;
      end
      if (data_w) begin
        if (usb_beat_i.last) begin
          fcnt_q <= '0;
          end_q  <= short_w;
        end else begin
          fcnt_q <= fcnt_w;
        end
      end
      // Phase ends only once the short frame is ACKed
      // A bad frame is resent, so its count starts over
      if (commit_o && end_q) begin
        data_q <= 1'b0;
        end_q  <= 1'b0;
      end else if (drop_o) begin
        end_q  <= 1'b0;
        fcnt_q <= '0;
      end
    end
  end

  a_cmd_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    cmd_valid_o && !cmd_ready_i && !clear_w |=> cmd_valid_o && $stable(cmd_o));

  // No beat reaches the buffer and no command leaves while halted
  a_stall_quiet: assert property (@(posedge clock) disable iff (!rst_n_i)
    stalled_o |-> !wr_valid_o && !cmd_valid_o);

endmodule

// ==== packet_fifo.sv ====
`timescale 1ns/1ps

module packet_fifo (
  input  logic                      clock,
  input  logic                      rst_n_i,
  input  logic                      wr_valid_i,
  output logic                      wr_ready_o,
  input  usb_stream_pkg::usb_beat_t wr_beat_i,
  input  logic                      commit_i,
  input  logic                      drop_i,
  output logic                      rd_valid_o,
  input  logic                      rd_ready_i,
  output usb_stream_pkg::usb_beat_t rd_beat_o
);

  import usb_stream_pkg::*;

  usb_beat_t        mem_q [FIFO_DEPTH];

  // One extra bit tells full from empty
  logic [FIFO_AW:0] wr_ptr_q;
  logic [FIFO_AW:0] cm_ptr_q;
  logic [FIFO_AW:0] rd_ptr_q;

  logic [FIFO_AW:0] used_w;
  logic [FIFO_AW:0] avail_w;
  logic             wr_w;
  logic             rd_w;

  // Space counts speculative bytes too
  assign used_w     = wr_ptr_q - rd_ptr_q;
  // Reader only sees committed bytes
  assign avail_w    = cm_ptr_q - rd_ptr_q;
  assign wr_ready_o = used_w < (FIFO_AW + 1)'(FIFO_DEPTH);
  assign rd_valid_o = avail_w != '0;

  // A ZDP is accepted but stores nothing
  assign wr_w = wr_valid_i && wr_ready_o && wr_beat_i.keep && !drop_i;
  assign rd_w = rd_valid_o && rd_ready_i;

  always_ff @(posedge clock) begin
    if (wr_w) begin
      mem_q[wr_ptr_q[FIFO_AW-1:0]] <= wr_beat_i;
    end
  end

  assign rd_beat_o = mem_q[rd_ptr_q[FIFO_AW-1:0]];

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      cm_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      // Bad frame, rewind to the last commit point
      if (drop_i) begin
        wr_ptr_q <= cm_ptr_q;
      end else if (wr_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // Frame ACKed, its bytes become readable next cycle
      if (commit_i && !drop_i) begin
        cm_ptr_q <= wr_ptr_q;
      end
      if (rd_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Held bytes never outnumber the buffer slots
  a_no_write_full: assert property (@(posedge clock) disable iff (!rst_n_i)
    used_w <= (FIFO_AW + 1)'(FIFO_DEPTH));

  // Reads stay behind the commit point and return real bytes
  a_no_read_empty: assert property (@(posedge clock) disable iff (!rst_n_i)
    rd_w |-> avail_w <= used_w && rd_beat_o.keep);

endmodule

// ==== tb_mmio_bridge.sv ====
`timescale 1ns/1ps

module tb_mmio_bridge;

  import usb_stream_pkg::*;
  import mmio_cmd_pkg::*;

  localparam int TIMEOUT = 2000;
  localparam int NUM_TESTS = 11;
  // Slave answers PSLVERR here and keeps its word
  localparam logic [31:0] ERR_ADDR = 32'h2000_003c;
  localparam logic [1:0] K_GOOD = 2'd0;
  localparam logic [1:0] K_MAGIC = 2'd1;
  localparam logic [1:0] K_LEN = 2'd2;
  localparam logic [3:0] NO_DROP = 4'hf;

  // One table row: packet to send and what must come back
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  tag;
    logic        dir;
    logic [1:0]  op;
    logic [3:0]  lun;
    logic [27:0] adr;
    logic [15:0] lenval;
    logic [3:0]  drop_frame;
    logic        waits;
    logic        exp_err;
  } entry_t;

  logic        clock;
  logic        rst_n;
  logic        set_conf;
  logic        clr_conf;
  logic        selected;
  logic        rx_error;
  logic        ack_sent;
  logic        usb_valid;
  usb_beat_t   usb_beat;
  logic        usb_ready;
  logic        stalled;
  logic        resp_valid;
  mmio_resp_t  resp;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  entry_t      table_q [NUM_TESTS];
  logic [31:0] mem [1024];
  logic [31:0] exp_mem [1024];
  logic [7:0]  frame_q [$];
  logic [7:0]  payload [$];
  mmio_resp_t  resp_q [$];
  logic        wait_en;
  int          apb_count;
  int          errors;
  int          passed;
  int          seed;

  mmio_bridge_top dut_i (
    .clock        (clock),
    .rst_n_i      (rst_n),
    .set_conf_i   (set_conf),
    .clr_conf_i   (clr_conf),
    .selected_i   (selected),
    .rx_error_i   (rx_error),
    .ack_sent_i   (ack_sent),
    .usb_valid_i  (usb_valid),
    .usb_beat_i   (usb_beat),
    .usb_ready_o  (usb_ready),
    .stalled_o    (stalled),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .paddr_o      (paddr),
    .psel_o       (psel),
    .penable_o    (penable),
    .pwrite_o     (pwrite),
    .pwdata_o     (pwdata),
    .prdata_i     (prdata),
    .pready_i     (pready),
    .pslverr_i    (pslverr)
  );

  always #5 clock = ~clock;

  // Word index, LUN nibble plus low address bits
  function automatic logic [9:0] mem_idx(input logic [31:0] a);
    return {a[31:28], a[7:2]};
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    return 32'hc3a5_0000 ^ (i * 32'h0001_0003);
  endfunction

  function automatic entry_t make_entry(input logic [1:0] kind, input logic [3:0] tag,
                                        input logic dir, input logic [1:0] op,
                                        input logic [3:0] lun, input logic [27:0] adr,
                                        input logic [15:0] lenval, input logic [3:0] drop,
                                        input logic waits, input logic exp_err);
    entry_t e;
    e.kind       = kind;
    e.tag        = tag;
    e.dir        = dir;
    e.op         = op;
    e.lun        = lun;
    e.adr        = adr;
    e.lenval     = lenval;
    e.drop_frame = drop;
    e.waits      = waits;
    e.exp_err    = exp_err;
    return e;
  endfunction

  // APB slave memory, random wait states when enabled
  assign prdata  = (psel && paddr != ERR_ADDR) ? mem[mem_idx(paddr)] : 32'h0;
  assign pslverr = psel && penable && paddr == ERR_ADDR;

  always @(posedge clock) begin
    if (psel && penable && pready) begin
      apb_count <= apb_count + 1;
      if (pwrite && paddr != ERR_ADDR) begin
        mem[mem_idx(paddr)] <= pwdata;
      end
    end
    pready <= wait_en ? ($urandom % 3 != 0) : 1'b1;
  end

  // Response pulses are caught whatever the main thread is doing
  always @(negedge clock) begin
    if (resp_valid) begin
      resp_q.push_back(resp);
    end
  end

  // Sends frame_q as one USB frame, an empty queue gives a ZDP
  task automatic send_frame(output bit aborted);
    int n;
    int i;
    int t;
    bit hs;
    begin
      aborted = 0;
      n = frame_q.size();
      for (i = 0; i < ((n == 0) ? 1 : n) && !aborted; i++) begin
        usb_valid <= 1'b1;
        if (n == 0) begin
          usb_beat <= {1'b1, 1'b0, 8'h00};
        end else begin
          usb_beat <= {i == n - 1, 1'b1, frame_q[i]};
        end
        hs = 0;
        t  = 0;
        while (!hs && !aborted) begin
          @(negedge clock);
          if (usb_ready) begin
            hs = 1;
          end else if (stalled) begin
            aborted = 1;
          end else if (t > TIMEOUT) begin
            $display("timeout waiting for usb_ready at byte %0d", i);
            errors++;
            aborted = 1;
          end
          t++;
          @(posedge clock);
        end
      end
      usb_valid <= 1'b0;
    end
  endtask

  task automatic pulse_ack();
    ack_sent <= 1'b1;
    @(posedge clock);
    ack_sent <= 1'b0;
  endtask

  task automatic pulse_rx_error();
    rx_error <= 1'b1;
    @(posedge clock);
    rx_error <= 1'b0;
  endtask

  task automatic reconfigure();
    clr_conf <= 1'b1;
    @(posedge clock);
    clr_conf <= 1'b0;
    set_conf <= 1'b1;
    @(posedge clock);
    set_conf <= 1'b0;
    @(posedge clock);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_memory();
    int i;
    for (i = 0; i < 1024; i++) begin
      if (mem[i] !== exp_mem[i]) begin
        $display("mismatch mem[%h]: got %h expected %h", i, mem[i], exp_mem[i]);
        errors++;
      end
    end
  endtask

  task automatic run_test(input int n);
    entry_t      e;
    int          start_err;
    int          base_count;
    int          exp_count;
    int          off;
    int          flen;
    int          f;
    int          k;
    int          t;
    bit          ab;
    logic [31:0] addr;
    logic [15:0] exp_rdata;
    mmio_resp_t  r;
    begin
      e          = table_q[n];
      start_err  = errors;
      wait_en    <= e.waits;
      base_count = apb_count;
      addr       = {e.lun, e.adr};
      payload.delete();
      if (e.op == OP_STORE) begin
        for (k = 0; k < e.lenval; k++) begin
          payload.push_back(8'($urandom));
        end
      end
      // Magic, address and length go out little-endian
      frame_q.delete();
      for (k = 0; k < 4; k++) begin
        frame_q.push_back(MMIO_MAGIC[8*k +: 8]);
      end
      for (k = 0; k < 4; k++) begin
        frame_q.push_back(addr[8*k +: 8]);
      end
      frame_q.push_back(e.lenval[7:0]);
      frame_q.push_back(e.lenval[15:8]);
      frame_q.push_back({e.tag, e.dir, 1'b0, e.op});
      if (e.kind == K_MAGIC) begin
        frame_q[3] = frame_q[3] ^ 8'h20;
      end
      if (e.kind == K_LEN) begin
        void'(frame_q.pop_back());
      end
      send_frame(ab);
      if (e.kind != K_GOOD) begin
        t = 0;
        while (!stalled && t < TIMEOUT) begin
          @(negedge clock);
          t++;
        end
        if (!stalled) begin
          $display("test %0d: bad packet did not raise the stall", n);
          errors++;
        end
        // Endpoint refuses the host until reconfigured
        check_value("usb_ready_o", usb_ready, 0);
        repeat (4) @(posedge clock);
        check_value("apb_count", apb_count, base_count);
        check_value("resp_count", resp_q.size(), 0);
        reconfigure();
        check_value("stalled_o", stalled, 0);
      end else begin
        if (ab) begin
          $display("test %0d: command packet was not accepted", n);
          errors++;
        end
        // Data frames, a full last frame needs a trailing ZDP
        if (e.op == OP_STORE) begin
          off = 0;
          f   = 0;
          do begin
            flen = e.lenval - off;
            if (flen > USB_MAX_PACKET) begin
              flen = USB_MAX_PACKET;
            end
            frame_q.delete();
            for (k = 0; k < flen; k++) begin
              frame_q.push_back(payload[off + k]);
            end
            if (f == e.drop_frame) begin
              send_frame(ab);
              pulse_rx_error();
            end
            send_frame(ab);
            pulse_ack();
            off += flen;
            f++;
          end while (flen == USB_MAX_PACKET);
        end
        t = 0;
        while (resp_q.size() == 0 && t < TIMEOUT) begin
          @(posedge clock);
          t++;
        end
        exp_rdata = '0;
        exp_count = 1;
        if (e.op == OP_SINGLE && e.dir) begin
          exp_rdata = exp_mem[mem_idx(addr)][15:0];
        end else if (e.op == OP_SINGLE) begin
          // The transfer still happens on the error address
          if (addr != ERR_ADDR) begin
            exp_mem[mem_idx(addr)] = {16'h0000, e.lenval};
          end
        end else if (e.op == OP_STORE) begin
          exp_count = e.lenval / 4;
          for (k = 0; k < e.lenval / 4; k++) begin
            exp_mem[mem_idx(addr + 4 * k)] = {payload[4*k+3], payload[4*k+2],
                                               payload[4*k+1], payload[4*k]};
          end
        end else begin
          exp_count = 0;
        end
        if (resp_q.size() == 0) begin
          $display("test %0d: no response within %0d cycles", n, TIMEOUT);
          errors++;
        end else begin
          r = resp_q.pop_front();
          check_value("resp.tag", r.tag, e.tag);
          check_value("resp.err", r.err, e.exp_err);
          check_value("resp.rdata", r.rdata, exp_rdata);
        end
        check_value("apb_count", apb_count - base_count, exp_count);
        check_value("stalled_o", stalled, 0);
      end
      check_memory();
      if (errors == start_err) begin
        passed++;
        $display("test %0d tag %h: pass", n, e.tag);
      end else begin
        $display("test %0d tag %h: FAIL", n, e.tag);
      end
    end
  endtask

  initial begin
    int i;
    seed      = $urandom(79117);
    clock     = 1'b0;
    rst_n     = 1'b0;
    set_conf  = 1'b0;
    clr_conf  = 1'b0;
    selected  = 1'b1;
    rx_error  = 1'b0;
    ack_sent  = 1'b0;
    usb_valid = 1'b0;
    usb_beat  = '0;
    pready    = 1'b1;
    wait_en   = 1'b0;
    apb_count = 0;
    errors    = 0;
    passed    = 0;
    for (i = 0; i < 1024; i++) begin
      mem[i]     = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
    table_q[0]  = make_entry(K_GOOD, 4'h1, 0, OP_SINGLE, 4'h0, 28'h10, 16'hbeef, NO_DROP, 0, 0);
    table_q[1]  = make_entry(K_GOOD, 4'h2, 1, OP_SINGLE, 4'h0, 28'h10, 16'h0, NO_DROP, 0, 0);
    table_q[2]  = make_entry(K_GOOD, 4'h3, 0, OP_STORE, 4'h0, 28'h40, 16'd100, NO_DROP, 0, 0);
    table_q[3]  = make_entry(K_GOOD, 4'h4, 0, OP_STORE, 4'h1, 28'h0, 16'd128, 4'd1, 0, 0);
    table_q[4]  = make_entry(K_MAGIC, 4'h5, 0, OP_SINGLE, 4'h0, 28'h14, 16'h5555, NO_DROP, 0, 0);
    table_q[5]  = make_entry(K_GOOD, 4'h6, 0, OP_SINGLE, 4'h2, 28'h8, 16'h1234, NO_DROP, 0, 0);
    table_q[6]  = make_entry(K_LEN, 4'h7, 0, OP_SINGLE, 4'h0, 28'h18, 16'h6666, NO_DROP, 0, 0);
    table_q[7]  = make_entry(K_GOOD, 4'h8, 1, OP_LOAD, 4'h0, 28'h20, 16'd8, NO_DROP, 0, 1);
    table_q[8]  = make_entry(K_GOOD, 4'h9, 0, OP_STORE, 4'h3, 28'h20, 16'd48, 4'd0, 1, 0);
    table_q[9]  = make_entry(K_GOOD, 4'ha, 0, OP_SINGLE, 4'h2, 28'h3c, 16'hdead, NO_DROP, 1, 1);
    table_q[10] = make_entry(K_GOOD, 4'hb, 1, OP_SINGLE, 4'h1, 28'h4, 16'h0, NO_DROP, 1, 0);
    repeat (2) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);
    // Idle outputs out of reset, endpoint closed until configured
    check_value("psel_o", psel, 0);
    check_value("penable_o", penable, 0);
    check_value("resp_valid_o", resp_valid, 0);
    check_value("usb_ready_o", usb_ready, 0);
    check_value("stalled_o", stalled, 0);
    set_conf <= 1'b1;
    @(posedge clock);
    set_conf <= 1'b0;
    @(posedge clock);
    for (i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d passed, %0d errors", NUM_TESTS, passed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== usb_stream_pkg.sv ====
package usb_stream_pkg;

  // One byte slot of a Bulk-Out stream
  typedef struct packed {
    // Final byte of a USB frame
    logic       last;
    // Low only on a zero-data packet, which carries no byte
    logic       keep;
    logic [7:0] data;
  } usb_beat_t;

  // Bulk max packet size in bytes
  // A shorter frame ends a store data phase
  localparam int USB_MAX_PACKET = 64;

  // Per-frame byte counter, must hold 0 up to USB_MAX_PACKET
  localparam int USB_FRAME_CW = $clog2(USB_MAX_PACKET) + 1;

  // Store data buffer, in bytes
  localparam int FIFO_DEPTH = 256;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage
